/* hw/tackPkg.sv */
// Transfer acknowledge shared types
// Counter widths for the ROM setup delay and the unclaimed-cycle timeout,
// plus the state encodings of the acknowledge driver and the CIA sequencer

package tackPkg;

    ////////////////////
    // Counter widths
    ////////////////////

    // ROM setup delay, a handful of CLK80 cycles
    typedef logic [2:0] romCountT;

    // Unclaimed cycle timeout, a few microseconds at 80 MHz
    typedef logic [7:0] timeoutCountT;

    ////////////////////
    // State machines
    ////////////////////

    // Acknowledge pulse shaping
    // Assert and Hold drive low, Negate drives high before release
    typedef enum logic [1:0] {
        tackIdle,
        tackAssert,
        tackHold,
        tackNegate
    } tackStateT;

    // CIA termination sequence
    typedef enum logic [1:0] {
        ciaIdle,
        ciaWaitHigh,
        ciaWaitLow,
        ciaDone
    } ciaStateT;

endpackage

/* hw/cycleMonitor.sv */
// Bus cycle monitor
// Flags the start of each CPU bus cycle and runs the unclaimed-cycle timeout.
// When nothing on the bus answers, a late acknowledge is requested so the
// CPU never hangs on an unmapped address.

`timescale 1ns/1ps

module cycleMonitor #(
    parameter tackPkg::timeoutCountT timeoutCycles = 8'd249
) (
    input  logic CLK80,
    input  logic DELAYED_TACK_RST,
    input  logic tsN,
    input  logic clk40,
    input  logic agnusSpace,
    input  logic tackIn,
    input  logic tackBusy,
    output logic cycleStart,
    output logic timeoutReq
);

    import tackPkg::*;

    timeoutCountT timeoutCount;
    logic         timeoutClear;

    // Any acknowledge on the bus, chip-set space, or our own driver at work
    // ends the need for a timeout
    assign timeoutClear = !tackIn || agnusSpace || tackBusy;

    ////////////////////
    // Cycle start
    ////////////////////

    // Transfer start only counts during the high phase of the bus clock
    always_ff @(posedge CLK80 or posedge DELAYED_TACK_RST) begin
        if (DELAYED_TACK_RST) begin
            cycleStart <= 1'b0;
        end else begin
            cycleStart <= !tsN && clk40;
        end
    end

    ////////////////////
    // Timeout counter
    ////////////////////

    always_ff @(posedge CLK80 or posedge DELAYED_TACK_RST) begin
        if (DELAYED_TACK_RST) begin
            timeoutCount <= '0;
            timeoutReq   <= 1'b0;
        end else begin
            // Single cycle pulse by default
            timeoutReq <= 1'b0;
            if (timeoutClear) begin
                timeoutCount <= '0;
            end else if (timeoutCount == '0) begin
                // Idle, arm on a new cycle
                if (cycleStart) timeoutCount <= timeoutCountT'(1);
            end else if (timeoutCount == timeoutCycles) begin
                timeoutReq   <= 1'b1;
                timeoutCount <= '0;
            end else begin
                timeoutCount <= timeoutCount + timeoutCountT'(1);
            end
        end
    end

endmodule

/* hw/romTackDelay.sv */
// ROM acknowledge delay
// Holds back the acknowledge of a ROM cycle long enough for the ROM
// to meet its access time, then requests a single acknowledge pulse.

`timescale 1ns/1ps

module romTackDelay #(
    parameter tackPkg::romCountT romDelayCycles = 3'd3
) (
    input  logic CLK80,
    input  logic DELAYED_TACK_RST,
    input  logic cycleStart,
    input  logic romEn,
    output logic romReq
);

    import tackPkg::*;

    // Zero means idle, otherwise cycles since the start was seen
    romCountT romCount;

    ////////////////////
    // Setup delay
    ////////////////////

    always_ff @(posedge CLK80 or posedge DELAYED_TACK_RST) begin
        if (DELAYED_TACK_RST) begin
            romCount <= '0;
            romReq   <= 1'b0;
        end else begin
            romReq <= 1'b0;
            if (romCount == '0) begin
                // Only a ROM-enabled start begins the delay
                if (cycleStart && romEn) begin
                    romCount <= romCountT'(1);
                end
            end else if (romCount == romDelayCycles) begin
                // Delay done, one request toward the driver
                romReq   <= 1'b1;
                romCount <= '0;
            end else begin
                // Starts seen in here are ignored
                romCount <= romCount + romCountT'(1);
            end
        end
    end

endmodule

/* hw/ciaTackSync.sv */
// CIA cycle termination
// The CIA select and the slow CIA clock are asynchronous to CLK80 and are
// synchronized first. A CIA cycle is acknowledged just after the CIA clock
// falls while the select is active, during the low phase of the bus clock.
// One request is made per assertion of the select.

`timescale 1ns/1ps

module ciaTackSync (
    input  logic CLK80,
    input  logic DELAYED_TACK_RST,
    input  logic ciaEnable,
    input  logic clkCia,
    input  logic clk40,
    output logic ciaReq
);

    import tackPkg::*;

    // Bit 0 is the metastable stage, bit 1 the usable one
    logic [1:0] ciaEnPipe;
    logic [1:0] clkCiaPipe;

    logic ciaEnSync;
    logic clkCiaSync;
    logic ciaFall;

    ciaStateT ciaState;

    ////////////////////
    // Synchronizers
    ////////////////////

    always_ff @(posedge CLK80 or posedge DELAYED_TACK_RST) begin
        if (DELAYED_TACK_RST) begin
            ciaEnPipe  <= 2'b00;
            clkCiaPipe <= 2'b00;
        end else begin
            ciaEnPipe  <= {ciaEnPipe[0], ciaEnable};
            clkCiaPipe <= {clkCiaPipe[0], clkCia};
        end
    end

    assign ciaEnSync  = ciaEnPipe[1];
    assign clkCiaSync = clkCiaPipe[1];

    // CIA clock seen low after a high, in the low half of the bus clock
    assign ciaFall = (ciaState == ciaWaitLow) && !clkCiaSync && !clk40;

    // Request taken straight from the decode, it lasts one cycle because
    // the FSM leaves WaitLow on the same edge
    assign ciaReq = ciaFall;

    ////////////////////
    // CIA sequencer
    ////////////////////

    always_ff @(posedge CLK80 or posedge DELAYED_TACK_RST) begin
        if (DELAYED_TACK_RST) begin
            ciaState <= ciaIdle;
        end else begin
            case (ciaState)
                ciaIdle: begin
                    if (ciaEnSync) ciaState <= ciaWaitHigh;
                end
                ciaWaitHigh: begin
                    // Select dropped before the CIA answered
                    if (!ciaEnSync) begin
                        ciaState <= ciaIdle;
                    end else if (clkCiaSync) begin
                        ciaState <= ciaWaitLow;
                    end
                end
                ciaWaitLow: begin
                    if (!ciaEnSync) begin
                        ciaState <= ciaIdle;
                    end else if (ciaFall) begin
                        ciaState <= ciaDone;
                    end
                end
                ciaDone: begin
                    // Hold here until the select goes away, one ack per select
                    if (!ciaEnSync) ciaState <= ciaIdle;
                end
                default: ciaState <= ciaIdle;
            endcase
        end
    end

endmodule

/* hw/tackDriver.sv */
// Transfer acknowledge driver
// Merges the ROM, CIA and timeout requests and shapes the acknowledge
// seen by the CPU: two cycles low, one cycle driven high, then released.
// Requests arriving while a pulse is in progress are dropped.

`timescale 1ns/1ps

module tackDriver (
    input  logic CLK80,
    input  logic DELAYED_TACK_RST,
    input  logic romReq,
    input  logic ciaReq,
    input  logic timeoutReq,
    output logic tackOut,
    output logic tackOe,
    output logic tackBusy
);

    import tackPkg::*;

    tackStateT tackState;
    logic      anyReq;

    assign anyReq = romReq || ciaReq || timeoutReq;

    // Lets the timeout know a pulse is already on its way
    assign tackBusy = (tackState != tackIdle);

    ////////////////////
    // Pulse shaper
    ////////////////////

    // Registered pin outputs so the bus sees clean edges
    always_ff @(posedge CLK80 or posedge DELAYED_TACK_RST) begin
        if (DELAYED_TACK_RST) begin
            tackState <= tackIdle;
            tackOut   <= 1'b1;
            tackOe    <= 1'b0;
        end else begin
            case (tackState)
                tackIdle: begin
                    if (anyReq) begin
                        tackState <= tackAssert;
                        tackOe    <= 1'b1;
                        tackOut   <= 1'b0;
                    end
                end
                // Second low cycle
                tackAssert: tackState <= tackHold;
                tackHold: begin
                    // Drive the line high before letting go
                    tackState <= tackNegate;
                    tackOut   <= 1'b1;
                end
                tackNegate: begin
                    tackState <= tackIdle;
                    tackOe    <= 1'b0;
                end
                default: begin
                    tackState <= tackIdle;
                    tackOut   <= 1'b1;
                    tackOe    <= 1'b0;
                end
            endcase
        end
    end

endmodule

/* hw/transferAck.sv */
// 68040/68060 transfer acknowledge
// Cycle termination for ROM, CIA and unclaimed bus cycles at 80 MHz.
// The bus pin is split into level, enable and sensed bus level;
// the tri-state buffer sits outside this block.

`timescale 1ns/1ps

module transferAck #(
    parameter tackPkg::romCountT     romDelayCycles = 3'd3,
    parameter tackPkg::timeoutCountT timeoutCycles  = 8'd249
) (
    input  logic CLK80,
    input  logic DELAYED_TACK_RST,
    input  logic clk40,
    input  logic tsN,
    input  logic romEn,
    input  logic ciaEnable,
    input  logic clkCia,
    input  logic agnusSpace,
    input  logic tackIn,
    output logic tackOut,
    output logic tackOe
);

    // Start of a bus cycle, one CLK80 wide
    logic cycleStart;

    // Single cycle requests into the driver
    logic romReq;
    logic ciaReq;
    logic timeoutReq;

    // Driver is mid-pulse
    logic tackBusy;

    ////////////////////
    // Cycle detect and timeout
    ////////////////////

    cycleMonitor #(
        .timeoutCycles(timeoutCycles)
    ) cycleMonitor_i (
        .CLK80           (CLK80),
        .DELAYED_TACK_RST(DELAYED_TACK_RST),
        .tsN             (tsN),
        .clk40           (clk40),
        .agnusSpace      (agnusSpace),
        .tackIn          (tackIn),
        .tackBusy        (tackBusy),
        .cycleStart      (cycleStart),
        .timeoutReq      (timeoutReq)
    );

    ////////////////////
    // ROM
    ////////////////////

    romTackDelay #(
        .romDelayCycles(romDelayCycles)
    ) romTackDelay_i (
        .CLK80           (CLK80),
        .DELAYED_TACK_RST(DELAYED_TACK_RST),
        .cycleStart      (cycleStart),
        .romEn           (romEn),
        .romReq          (romReq)
    );

    ////////////////////
    // CIA
    ////////////////////

    ciaTackSync ciaTackSync_i (
        .CLK80           (CLK80),
        .DELAYED_TACK_RST(DELAYED_TACK_RST),
        .ciaEnable       (ciaEnable),
        .clkCia          (clkCia),
        .clk40           (clk40),
        .ciaReq          (ciaReq)
    );

    ////////////////////
    // Pin driver
    ////////////////////

    tackDriver tackDriver_i (
        .CLK80           (CLK80),
        .DELAYED_TACK_RST(DELAYED_TACK_RST),
        .romReq          (romReq),
        .ciaReq          (ciaReq),
        .timeoutReq      (timeoutReq),
        .tackOut         (tackOut),
        .tackOe          (tackOe),
        .tackBusy        (tackBusy)
    );

endmodule

/* verification/tackDriver_assertions.sv */
// Acknowledge pulse shape checks
// Bound into the driver to watch the pin level and enable against the FSM

`timescale 1ns/1ps

module tackDriverAssertions (
    input logic               CLK80,
    input logic               DELAYED_TACK_RST,
    input logic               tackOut,
    input logic               tackOe,
    input tackPkg::tackStateT tackState
);

    import tackPkg::*;

    // Low level only ever appears on a driven line
    lowNeedsOe: assert property (@(posedge CLK80) disable iff (DELAYED_TACK_RST)
        !tackOut |-> tackOe)
        else $error("tackOut low while tackOe is low");

    // First low cycle is followed by a second one
    lowSecondCycle: assert property (@(posedge CLK80) disable iff (DELAYED_TACK_RST)
        (!tackOut && $past(tackOut)) |=> !tackOut)
        else $error("tackOut low pulse shorter than two cycles");

    // Never a third low cycle
    lowNoThird: assert property (@(posedge CLK80) disable iff (DELAYED_TACK_RST)
        (!tackOut && $past(!tackOut)) |=> tackOut)
        else $error("tackOut low pulse longer than two cycles");

    // End of pulse drives high, then the line is released
    highDriven: assert property (@(posedge CLK80) disable iff (DELAYED_TACK_RST)
        (tackOut && $past(!tackOut)) |-> tackOe)
        else $error("tackOut not driven high after low pulse");

    releaseAfterHigh: assert property (@(posedge CLK80) disable iff (DELAYED_TACK_RST)
        (tackOut && $past(!tackOut)) |=> !tackOe)
        else $error("tackOe not released after the high cycle");

    // Driver is busy for exactly the cycles it drives the line
    busyMatchesOe: assert property (@(posedge CLK80) disable iff (DELAYED_TACK_RST)
        (tackState != tackIdle) == tackOe)
        else $error("driver state and tackOe disagree");

endmodule

/* verification/transferAckTb.sv */
// Transfer acknowledge testbench
// Directed tests for ROM, CIA and unclaimed bus cycles.
// The acknowledge line is resolved here from the DUT drive and a second device.

`timescale 1ns/1ps

module transferAckTb;

    import tackPkg::*;

    // DUT defaults, expected latencies follow from these
    localparam romCountT     romDelay   = 3'd3;
    localparam timeoutCountT timeoutLen = 8'd249;

    // CIA clock half period in CLK80 cycles, select edge, edges per CIA run
    localparam int ciaHalf     = 10;
    localparam int ciaSelEdge  = 4;
    localparam int ciaRunEdges = 80;

    // Tests take about 2000 cycles, generous margin on top
    localparam int cycleLimit = 5000;

    logic CLK80;
    logic DELAYED_TACK_RST;
    logic clk40;
    logic tsN;
    logic romEn;
    logic ciaEnable;
    logic clkCia;
    logic agnusSpace;
    logic tackIn;
    logic tackOut;
    logic tackOe;
    logic otherDevAck;

    int errorCount;
    int testCount;
    int failedTests;
    int cycleCount;
    int seed;

    transferAck dut_i (
        .CLK80           (CLK80),
        .DELAYED_TACK_RST(DELAYED_TACK_RST),
        .clk40           (clk40),
        .tsN             (tsN),
        .romEn           (romEn),
        .ciaEnable       (ciaEnable),
        .clkCia          (clkCia),
        .agnusSpace      (agnusSpace),
        .tackIn          (tackIn),
        .tackOut         (tackOut),
        .tackOe          (tackOe)
    );

    bind tackDriver tackDriverAssertions tackDriverAssertions_i (
        .CLK80           (CLK80),
        .DELAYED_TACK_RST(DELAYED_TACK_RST),
        .tackOut         (tackOut),
        .tackOe          (tackOe),
        .tackState       (tackState)
    );

    // Bus with pull-up, our drive wins while enabled
    assign tackIn = tackOe ? tackOut : !otherDevAck;

    ////////////////////
    // Clocks and timeout
    ////////////////////

    initial begin
        CLK80 = 1'b0;
        forever #20 CLK80 = !CLK80;
    end

    // CPU bus clock level, half the CLK80 rate
    always @(posedge CLK80 or posedge DELAYED_TACK_RST) begin
        if (DELAYED_TACK_RST) clk40 <= 1'b0;
        else clk40 <= !clk40;
    end

    always @(posedge CLK80 or posedge DELAYED_TACK_RST) begin
        if (DELAYED_TACK_RST) begin
            cycleCount <= 0;
        end else begin
            cycleCount <= cycleCount + 1;
            if (cycleCount == cycleLimit) begin
                $display("Run stopped after %0d cycles without finishing", cycleLimit);
                $display("Simulation FAILED");
                $finish;
            end
        end
    end

    ////////////////////
    // Helpers
    ////////////////////

    task automatic checkValue(input string name, input int actual, input int expected);
        if (actual != expected) begin
            $display("[ERROR] %0t %s: got %0d, expected %0d", $time, name, actual, expected);
            errorCount++;
        end
    endtask

    task automatic noteFailure(input string what);
        $display("Failure at %0t: %s", $time, what);
        errorCount++;
    endtask

    task automatic finishTest(input string name, input int errorsBefore);
        testCount++;
        if (errorCount > errorsBefore) begin
            failedTests++;
            $display("%s: fail, %0d errors", name, errorCount - errorsBefore);
        end else begin
            $display("%s: pass", name);
        end
    endtask

    // Drop tsN for the cycle that ends on the start edge, returns at that edge
    task automatic startBusCycle();
        @(negedge CLK80);
        while (clk40) @(negedge CLK80);
        @(posedge CLK80);
        tsN <= 1'b0;
        @(posedge CLK80);
        tsN <= 1'b1;
    endtask

    // Edge index of the first driven cycle, -1 if none within the window
    task automatic waitAck(input int maxEdges, output int edgeIdx);
        int n;
        n = 0;
        edgeIdx = -1;
        while (edgeIdx < 0 && n <= maxEdges) begin
            @(negedge CLK80);
            if (tackOe) edgeIdx = n;
            n++;
        end
    endtask

    task automatic expectNoAck(input int maxEdges, input string what);
        int idx;
        waitAck(maxEdges, idx);
        if (idx >= 0) noteFailure($sformatf("acknowledge %0d cycles into %s", idx, what));
    endtask

    // Two low cycles, one driven high, then released
    task automatic checkPulse();
        checkValue("tackOut", int'(tackOut), 0);
        @(negedge CLK80);
        checkValue("tackOe", int'(tackOe), 1);
        checkValue("tackOut", int'(tackOut), 0);
        @(negedge CLK80);
        checkValue("tackOe", int'(tackOe), 1);
        checkValue("tackOut", int'(tackOut), 1);
        @(negedge CLK80);
        checkValue("tackOe", int'(tackOe), 0);
    endtask

    ////////////////////
    // Tests
    ////////////////////

    task automatic idleBus();
        int errorsBefore;
        errorsBefore = errorCount;
        repeat (20) begin
            @(negedge CLK80);
            checkValue("tackOe", int'(tackOe), 0);
            checkValue("tackOut", int'(tackOut), 1);
        end
        finishTest("idleBus", errorsBefore);
    endtask

    task automatic romCycles();
        int errorsBefore;
        int idx;
        int i;
        errorsBefore = errorCount;
        @(posedge CLK80);
        romEn <= 1'b1;
        // Back to back, each cycle starts right after the previous release
        for (i = 0; i < 3; i++) begin
            startBusCycle();
            waitAck(20, idx);
            if (idx < 0) begin
                noteFailure("no acknowledge for ROM cycle");
            end else begin
                checkValue("tackOut fall edge", idx, int'(romDelay) + 2);
                checkPulse();
            end
        end
        @(posedge CLK80);
        romEn <= 1'b0;
        finishTest("romCycles", errorsBefore);
    endtask

    task automatic ciaCycles();
        logic [31:0] rndBits;
        logic        ciaLevel;
        logic        sawHigh;
        logic        oePrev;
        int          errorsBefore;
        int          iter;
        int          k;
        int          ciaDiv;
        int          fallEdge;
        int          ackEdge;
        int          pulses;
        errorsBefore = errorCount;
        for (iter = 0; iter < 4; iter++) begin
            // Random starting level and divider phase of the CIA clock
            rndBits  = $random(seed);
            ciaLevel = rndBits[0];
            ciaDiv   = int'(rndBits[7:4]) % ciaHalf;
            sawHigh  = 1'b0;
            oePrev   = 1'b0;
            fallEdge = -1;
            ackEdge  = -1;
            pulses   = 0;
            for (k = 0; k < ciaRunEdges; k++) begin
                @(posedge CLK80);
                if (ciaDiv == ciaHalf - 1) begin
                    ciaDiv   = 0;
                    ciaLevel = !ciaLevel;
                    // First fall after a high seen behind the select synchronizer
                    if (!ciaLevel && sawHigh && fallEdge < 0) fallEdge = k;
                end else begin
                    ciaDiv++;
                end
                if (ciaLevel && k > ciaSelEdge) sawHigh = 1'b1;
                clkCia <= ciaLevel;
                if (k == ciaSelEdge) ciaEnable <= 1'b1;
                @(negedge CLK80);
                if (tackOe && !oePrev) begin
                    pulses++;
                    if (ackEdge < 0) ackEdge = k;
                end
                oePrev = tackOe;
            end
            if (fallEdge < 0) begin
                noteFailure("CIA clock never fell after the select");
            end else if (ackEdge < 0) begin
                noteFailure("no acknowledge for CIA cycle");
            end else if (ackEdge < fallEdge + 3 || ackEdge > fallEdge + 4) begin
                noteFailure($sformatf("CIA acknowledge at edge %0d, window %0d to %0d",
                                      ackEdge, fallEdge + 3, fallEdge + 4));
            end
            checkValue("CIA acknowledge pulses", pulses, 1);
            @(posedge CLK80);
            ciaEnable <= 1'b0;
            // Let the select drain through the synchronizer
            repeat (6) @(posedge CLK80);
        end
        finishTest("ciaCycles", errorsBefore);
    endtask

    task automatic unclaimedTimeout();
        int errorsBefore;
        int idx;
        errorsBefore = errorCount;
        startBusCycle();
        waitAck(int'(timeoutLen) + 10, idx);
        if (idx < 0) begin
            noteFailure("no timeout acknowledge for unclaimed cycle");
        end else begin
            checkValue("tackOut fall edge", idx, int'(timeoutLen) + 2);
            checkPulse();
        end
        finishTest("unclaimedTimeout", errorsBefore);
    endtask

    task automatic timeoutCancel();
        int errorsBefore;
        errorsBefore = errorCount;
        // Another device answers mid-count
        startBusCycle();
        expectNoAck(99, "cycle before other device ack");
        @(posedge CLK80);
        otherDevAck <= 1'b1;
        @(posedge CLK80);
        otherDevAck <= 1'b0;
        expectNoAck(int'(timeoutLen) + 10 - 101, "cycle answered by other device");
        // Chip-set space never times out
        @(posedge CLK80);
        agnusSpace <= 1'b1;
        startBusCycle();
        expectNoAck(int'(timeoutLen) + 10, "chip-set space cycle");
        @(posedge CLK80);
        agnusSpace <= 1'b0;
        finishTest("timeoutCancel", errorsBefore);
    endtask

    task automatic romSingleAck();
        int errorsBefore;
        int idx;
        errorsBefore = errorCount;
        @(posedge CLK80);
        romEn <= 1'b1;
        startBusCycle();
        waitAck(20, idx);
        if (idx < 0) begin
            noteFailure("no acknowledge for ROM cycle");
        end else begin
            checkPulse();
        end
        @(posedge CLK80);
        romEn <= 1'b0;
        // Own acknowledge must have cleared the pending timeout
        expectNoAck(int'(timeoutLen) + 10, "time after ROM acknowledge");
        finishTest("romSingleAck", errorsBefore);
    endtask

    ////////////////////
    // Main sequence
    ////////////////////

    initial begin
        errorCount  = 0;
        testCount   = 0;
        failedTests = 0;
        seed        = 32'h535b3535;
        DELAYED_TACK_RST <= 1'b1;
        tsN         <= 1'b1;
        romEn       <= 1'b0;
        ciaEnable   <= 1'b0;
        clkCia      <= 1'b0;
        agnusSpace  <= 1'b0;
        otherDevAck <= 1'b0;
        repeat (3) @(posedge CLK80);
        DELAYED_TACK_RST <= 1'b0;

        idleBus();
        romCycles();
        ciaCycles();
        unclaimedTimeout();
        timeoutCancel();
        romSingleAck();

        $display("Tests run: %0d, failed: %0d, errors: %0d", testCount, failedTests, errorCount);
        if (errorCount == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

/* project.f */
hw/tackPkg.sv
hw/cycleMonitor.sv
hw/romTackDelay.sv
hw/ciaTackSync.sv
hw/tackDriver.sv
hw/transferAck.sv
verification/tackDriver_assertions.sv
verification/transferAckTb.sv

/* run.sh */
#!/bin/sh
# Build and run the transfer acknowledge testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
    --top-module transferAckTb \
    --Mdir obj_dir \
    -f project.f

# An assertion stop ends the binary with an error, the search below decides
out="$(./obj_dir/VtransferAckTb)" || true
echo "$out"

if echo "$out" | grep -q "Simulation PASSED"; then
    exit 0
fi
echo "run did not pass"
exit 1
